// File: axi_wm_vectors.txt
# start address (hex, 4 KB aligned)  size in bytes (decimal)
# one write request per line, queued in order
00000000 1
00001000 4
00002000 7
00003000 1024
00004000 1025
00005000 1026
00006000 2047
0000a000 3000
00010000 4096
00020000 14
00021000 513
00022000 1023
00030000 5000
00031000 2
00040000 259
00041000 2048
00050000 3
00051000 1101

// File: list.f
axi_wm_pkg.sv
sync_fifo.sv
write_plan_if.sv
burst_planner.sv
wdata_channel.sv
waddr_channel.sv
bresp_tracker.sv
axi_write_master.sv
tb_axi_write_master.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the AXI4 write master testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary -Wno-fatal --top-module tb_axi_write_master -f list.f -o sim_axi_wm
./obj_dir/sim_axi_wm | tee sim.log
if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: tb_axi_write_master.sv
// Testbench for the AXI4 write master: request driver, stream source, slave model and checkers
`default_nettype none

module tb_axi_write_master;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES  = 16;
  localparam int READY_TIMEOUT = 50000;
  localparam int DONE_TIMEOUT  = 400000;
  localparam int B_HOLD_CYCLES = 2000;

  logic        aclk;
  logic        areset;
  logic        ctrl_start;
  logic [31:0] ctrl_addr_offset;
  logic [19:0] ctrl_xfer_size_in_bytes;
  logic        ctrl_ready;
  logic        ctrl_done;
  logic        m_axi_awvalid;
  logic        m_axi_awready;
  logic [31:0] m_axi_awaddr;
  logic [7:0]  m_axi_awlen;
  logic        m_axi_wvalid;
  logic        m_axi_wready;
  logic [31:0] m_axi_wdata;
  logic [3:0]  m_axi_wstrb;
  logic        m_axi_wlast;
  logic        m_axi_bvalid;
  logic        m_axi_bready;
  logic        s_axis_tvalid;
  logic        s_axis_tready;
  logic [31:0] s_axis_tdata;

  // Expected AW and W sequences, filled as requests are accepted
  logic [31:0] exp_aw_addr[$];
  logic [7:0]  exp_aw_len[$];
  logic        exp_wlast[$];
  logic [3:0]  exp_wstrb[$];
  // Running burst total each request must reach before its done
  int          exp_done_bursts[$];

  int   errors       = 0;
  int   req_sent     = 0;
  int   req_acc      = 0;
  int   done_cnt     = 0;
  int   aw_acc       = 0;
  int   w_beats      = 0;
  int   wlast_cnt    = 0;
  int   w_started    = 0;
  int   b_cnt        = 0;
  int   b_issued     = 0;
  int   cum_bursts   = 0;
  int   stream_total = 0;
  int   stream_sent  = 0;
  logic w_first      = 1'b1;
  logic timed_out    = 1'b0;

  axi_write_master u_dut (.*);

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  ////////////////////
  // Reference helpers
  ////////////////////
  // Last beat keeps the low size mod 4 lanes, all four on a whole word
  function automatic logic [3:0] tail_strobe(input int size);
    int rem;
    rem = size % 4;
    tail_strobe = (rem == 0) ? 4'hf : 4'((1 << rem) - 1);
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("Error at %0d ns: %s got %h expected %h", $time, name, got, exp);
  endtask

  // Bursts of up to 256 beats, 1 KB apart, tail burst holds the rest
  task automatic expect_request(input logic [31:0] addr, input int size);
    int beats;
    int bursts;
    beats  = (size + 3) / 4;
    bursts = (beats + 255) / 256;
    for (int k = 0; k < bursts; k++) begin
      exp_aw_addr.push_back(addr + 32'(k * 1024));
      exp_aw_len.push_back((k == bursts - 1) ? 8'((beats - 1) % 256) : 8'd255);
    end
    for (int j = 0; j < beats; j++) begin
      exp_wlast.push_back((j % 256 == 255) || (j == beats - 1));
      exp_wstrb.push_back((j == beats - 1) ? tail_strobe(size) : 4'hf);
    end
    cum_bursts += bursts;
    exp_done_bursts.push_back(cum_bursts);
    stream_total += beats;
  endtask

  task automatic check_reset_state();
    if (m_axi_awvalid !== 1'b0) report_mismatch("m_axi_awvalid", 32'(m_axi_awvalid), 32'd0);
    if (m_axi_wvalid !== 1'b0) report_mismatch("m_axi_wvalid", 32'(m_axi_wvalid), 32'd0);
    if (ctrl_done !== 1'b0) report_mismatch("ctrl_done", 32'(ctrl_done), 32'd0);
    if (ctrl_ready !== 1'b1) report_mismatch("ctrl_ready", 32'(ctrl_ready), 32'd1);
    if (s_axis_tready !== 1'b1) report_mismatch("s_axis_tready", 32'(s_axis_tready), 32'd1);
  endtask

  ////////////////////
  // Monitor
  ////////////////////
  // Sampled on the rising edge, before the DUT registers update
  always @(posedge aclk) begin
    if (!areset) begin
      if (m_axi_bready !== 1'b1) begin
        report_mismatch("m_axi_bready", 32'(m_axi_bready), 32'd1);
      end
      if (ctrl_start && ctrl_ready) begin
        req_acc++;
        expect_request(ctrl_addr_offset, int'(ctrl_xfer_size_in_bytes));
      end
      if (s_axis_tvalid && s_axis_tready) begin
        stream_sent++;
      end
      // Done belongs to the oldest open request, after all its B responses
      if (ctrl_done) begin
        done_cnt++;
        if (exp_done_bursts.size() == 0) begin
          errors++;
          $display("ctrl_done pulsed at %0d ns with no request open", $time);
        end else begin
          if (b_cnt < exp_done_bursts[0]) begin
            errors++;
            $display("ctrl_done at %0d ns came before the final B of its request", $time);
          end
          void'(exp_done_bursts.pop_front());
        end
      end
      if (m_axi_bvalid && m_axi_bready) begin
        b_cnt++;
      end
      // First presented beat of a burst
      if (m_axi_wvalid && w_first) begin
        w_started++;
        w_first = 1'b0;
      end
      if (m_axi_wvalid && m_axi_wready) begin
        if (exp_wlast.size() == 0) begin
          errors++;
          $display("W beat at %0d ns with no beat expected", $time);
        end else begin
          if (m_axi_wdata !== 32'(w_beats)) begin
            report_mismatch("m_axi_wdata", m_axi_wdata, 32'(w_beats));
          end
          if (m_axi_wstrb !== exp_wstrb[0]) begin
            report_mismatch("m_axi_wstrb", 32'(m_axi_wstrb), 32'(exp_wstrb[0]));
          end
          if (m_axi_wlast !== exp_wlast[0]) begin
            report_mismatch("m_axi_wlast", 32'(m_axi_wlast), 32'(exp_wlast[0]));
          end
          void'(exp_wlast.pop_front());
          void'(exp_wstrb.pop_front());
        end
        w_beats++;
        if (m_axi_wlast) begin
          wlast_cnt++;
          w_first = 1'b1;
        end
      end
      if (m_axi_awvalid && m_axi_awready) begin
        if (aw_acc >= w_started) begin
          errors++;
          $display("AW at %0d ns issued before the first W beat of its burst", $time);
        end
        if (exp_aw_addr.size() == 0) begin
          errors++;
          $display("AW at %0d ns with no burst expected", $time);
        end else begin
          if (m_axi_awaddr !== exp_aw_addr[0]) begin
            report_mismatch("m_axi_awaddr", m_axi_awaddr, exp_aw_addr[0]);
          end
          if (m_axi_awlen !== exp_aw_len[0]) begin
            report_mismatch("m_axi_awlen", 32'(m_axi_awlen), 32'(exp_aw_len[0]));
          end
          void'(exp_aw_addr.pop_front());
          void'(exp_aw_len.pop_front());
        end
        aw_acc++;
        // Outstanding limit of four bursts
        if (aw_acc - b_cnt > 4) begin
          errors++;
          $display("More than 4 bursts outstanding at %0d ns", $time);
        end
      end
    end
  end

  ////////////////////
  // Slave model
  ////////////////////
  // Random ready, one B per burst once both its AW and wlast are in
  // Every fifth B is held back long enough to drain the credits
  initial begin
    int   b_wait;
    logic b_armed;
    void'($urandom(32'ha344));
    b_wait        = 0;
    b_armed       = 1'b0;
    m_axi_awready = 1'b0;
    m_axi_wready  = 1'b0;
    m_axi_bvalid  = 1'b0;
    forever begin
      @(negedge aclk);
      m_axi_awready = (($urandom % 4) != 0);
      m_axi_wready  = (($urandom % 4) != 0);
      m_axi_bvalid  = 1'b0;
      if (!b_armed && b_issued < aw_acc && b_issued < wlast_cnt) begin
        b_armed = 1'b1;
        if (b_issued % 5 == 0) begin
          b_wait = B_HOLD_CYCLES;
        end else begin
          b_wait = int'($urandom % 6);
        end
      end
      if (b_armed) begin
        if (b_wait == 0) begin
          m_axi_bvalid = 1'b1;
          b_issued++;
          b_armed = 1'b0;
        end else begin
          b_wait--;
        end
      end
    end
  end

  // Stream source, a running beat counter held until accepted
  initial begin
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    forever begin
      @(negedge aclk);
      s_axis_tvalid = (stream_sent < stream_total);
      s_axis_tdata  = 32'(stream_sent);
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    int          fd;
    int          size;
    int          wait_cycles;
    string       line;
    logic [31:0] addr;
    areset                  = 1'b1;
    ctrl_start              = 1'b0;
    ctrl_addr_offset        = '0;
    ctrl_xfer_size_in_bytes = '0;
    fd = $fopen("axi_wm_vectors.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open axi_wm_vectors.txt");
    end
    repeat (RESET_CYCLES) begin
      @(negedge aclk);
      check_reset_state();
    end
    areset = 1'b0;
    @(negedge aclk);
    check_reset_state();

    // Requests go in back to back whenever the queue has room
    while (fd != 0 && !timed_out && $fgets(line, fd) > 0) begin
      if ($sscanf(line, "%h %d", addr, size) == 2) begin
        wait_cycles = 0;
        while (!ctrl_ready && wait_cycles < READY_TIMEOUT) begin
          @(negedge aclk);
          wait_cycles++;
        end
        if (!ctrl_ready) begin
          timed_out = 1'b1;
          $display("Timeout: ctrl_ready stayed low for %0d cycles", READY_TIMEOUT);
        end else begin
          ctrl_start              = 1'b1;
          ctrl_addr_offset        = addr;
          ctrl_xfer_size_in_bytes = 20'(size);
          req_sent++;
          @(negedge aclk);
          ctrl_start = 1'b0;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    wait_cycles = 0;
    while (!timed_out && done_cnt < req_sent && wait_cycles < DONE_TIMEOUT) begin
      @(negedge aclk);
      wait_cycles++;
    end
    if (!timed_out && done_cnt < req_sent) begin
      timed_out = 1'b1;
      $display("Timeout: only %0d of %0d ctrl_done pulses seen", done_cnt, req_sent);
    end
    // Idle cycles to catch stray pulses
    repeat (20) @(negedge aclk);

    if (req_sent == 0) begin
      errors++;
      $display("No requests were read from the vector file");
    end
    if (req_acc != req_sent) begin
      errors++;
      $display("%0d requests driven but %0d accepted", req_sent, req_acc);
    end
    if (exp_aw_addr.size() != 0 || exp_wlast.size() != 0) begin
      errors++;
      $display("%0d AW bursts and %0d W beats never appeared",
               exp_aw_addr.size(), exp_wlast.size());
    end
    if (done_cnt != req_sent) begin
      errors++;
      $display("%0d ctrl_done pulses for %0d requests", done_cnt, req_sent);
    end
    $display("Summary: %0d errors, %0d requests, %0d AW, %0d W beats, %0d B, %0d done",
             errors, req_acc, aw_acc, w_beats, b_cnt, done_cnt);
    if (errors == 0 && !timed_out) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule : tb_axi_write_master

`default_nettype wire

// File: axi_write_master.sv
// AXI4 write master top level with request and data FIFOs and channel blocks
`default_nettype none

module axi_write_master (
  input  wire logic                                      aclk,
  input  wire logic                                      areset,
  // Request port
  input  wire logic                                      ctrl_start,
  input  wire axi_wm_pkg::addr_t                         ctrl_addr_offset,
  input  wire logic [axi_wm_pkg::XFER_SIZE_WIDTH-1:0]    ctrl_xfer_size_in_bytes,
  output logic                                           ctrl_ready,
  output logic                                           ctrl_done,
  // AXI4 write address
  output logic                                           m_axi_awvalid,
  input  wire logic                                      m_axi_awready,
  output axi_wm_pkg::addr_t                              m_axi_awaddr,
  output axi_wm_pkg::beat_cnt_t                          m_axi_awlen,
  // AXI4 write data
  output logic                                           m_axi_wvalid,
  input  wire logic                                      m_axi_wready,
  output axi_wm_pkg::data_t                              m_axi_wdata,
  output axi_wm_pkg::strb_t                              m_axi_wstrb,
  output logic                                           m_axi_wlast,
  // AXI4 write response
  input  wire logic                                      m_axi_bvalid,
  output logic                                           m_axi_bready,
  // AXI4-Stream data in
  input  wire logic                                      s_axis_tvalid,
  output logic                                           s_axis_tready,
  input  wire axi_wm_pkg::data_t                         s_axis_tdata
);
  import axi_wm_pkg::*;

  wr_request_t req_in;
  wr_request_t req_head;
  logic        req_full;
  logic        req_valid;
  logic        req_pop;
  logic        data_full;
  logic        data_valid;
  logic        data_pop;
  data_t       data_head;

  write_plan_if u_plan_if ();

  ////////////////////
  // Request queue
  ////////////////////
  assign req_in     = {ctrl_addr_offset, ctrl_xfer_size_in_bytes};
  assign ctrl_ready = ~req_full;

  sync_fifo #(.WIDTH($bits(wr_request_t)), .DEPTH(REQ_FIFO_DEPTH)) u_req_fifo (
    .aclk, .areset,
    .push(ctrl_start), .push_data(req_in), .full(req_full),
    .pop(req_pop), .pop_data(req_head), .not_empty(req_valid)
  );

  // Stream buffer, back-pressure straight from its full flag
  assign s_axis_tready = ~data_full;

  sync_fifo #(.WIDTH(DATA_WIDTH), .DEPTH(DATA_FIFO_DEPTH)) u_data_fifo (
    .aclk, .areset,
    .push(s_axis_tvalid), .push_data(s_axis_tdata), .full(data_full),
    .pop(data_pop), .pop_data(data_head), .not_empty(data_valid)
  );

  ////////////////////
  // Channel blocks
  ////////////////////
  burst_planner u_planner (
    .aclk, .areset, .req_valid, .req(req_head), .req_pop, .plan(u_plan_if.planner)
  );

  wdata_channel u_wdata (
    .aclk, .areset,
    .fifo_valid(data_valid), .fifo_data(data_head), .fifo_pop(data_pop),
    .plan(u_plan_if.wdata),
    .wvalid(m_axi_wvalid), .wready(m_axi_wready), .wdata(m_axi_wdata),
    .wstrb(m_axi_wstrb), .wlast(m_axi_wlast)
  );

  waddr_channel u_waddr (
    .aclk, .areset, .plan(u_plan_if.waddr),
    .awvalid(m_axi_awvalid), .awready(m_axi_awready),
    .awaddr(m_axi_awaddr), .awlen(m_axi_awlen)
  );

  bresp_tracker u_bresp (
    .aclk, .areset, .bvalid(m_axi_bvalid), .bready(m_axi_bready), .plan(u_plan_if.bresp)
  );

  assign ctrl_done = u_plan_if.done;

endmodule : axi_write_master

`default_nettype wire

// File: bresp_tracker.sv
// B response counting and request done pulse
`default_nettype none

module bresp_tracker (
  input  wire logic   aclk,
  input  wire logic   areset,
  input  wire logic   bvalid,
  output logic        bready,
  write_plan_if.bresp plan
);
  import axi_wm_pkg::*;

  txn_cnt_t b_txn_left;
  logic     b_final_txn;

  // Responses are always accepted
  assign bready    = 1'b1;
  assign plan.bxfer = bvalid & bready;

  ////////////////////
  // Response countdown
  ////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      b_txn_left <= '0;
    end else if (plan.plan_start) begin
      b_txn_left <= plan.num_transactions;
    end else if (plan.bxfer) begin
      b_txn_left <= b_txn_left - 1'b1;
    end
  end

  assign b_final_txn = (b_txn_left == '0);

  // One-cycle pulse after the last B of the request
  always_ff @(posedge aclk) begin
    if (areset) begin
      plan.done <= 1'b0;
    end else begin
      plan.done <= plan.bxfer & b_final_txn;
    end
  end

endmodule : bresp_tracker

`default_nettype wire

// File: waddr_channel.sv
// AW issue, address stepping, awlen and outstanding-burst credits
`default_nettype none

module waddr_channel (
  input  wire logic          aclk,
  input  wire logic          areset,
  write_plan_if.waddr        plan,
  output logic               awvalid,
  input  wire logic          awready,
  output axi_wm_pkg::addr_t  awaddr,
  output axi_wm_pkg::beat_cnt_t awlen
);
  import axi_wm_pkg::*;

  logic [MAX_W_TO_AW_WIDTH-1:0] w_to_aw;
  logic                         idle_aw;
  logic [OUTSTANDING_WIDTH-1:0] credits;
  logic                         stall_aw;
  txn_cnt_t                     aw_txn_left;
  logic                         aw_final_txn;
  addr_t                        addr;

  assign plan.awxfer = awvalid & awready;

  ////////////////////
  // Pending bursts
  ////////////////////
  // Bursts whose data has started but whose address is not yet out
  always_ff @(posedge aclk) begin
    if (areset) begin
      w_to_aw <= '0;
    end else if (plan.first_beat_pulse && !plan.awxfer) begin
      w_to_aw <= w_to_aw + 1'b1;
    end else if (plan.awxfer && !plan.first_beat_pulse) begin
      w_to_aw <= w_to_aw - 1'b1;
    end
  end

  assign idle_aw = (w_to_aw == '0);

  // Credits, spent per AW and returned per B
  always_ff @(posedge aclk) begin
    if (areset) begin
      credits <= OUTSTANDING_WIDTH'(MAX_OUTSTANDING);
    end else if (plan.awxfer && !plan.bxfer) begin
      credits <= credits - 1'b1;
    end else if (plan.bxfer && !plan.awxfer) begin
      credits <= credits + 1'b1;
    end
  end

  assign stall_aw = (credits == '0);

  ////////////////////
  // AW valid
  ////////////////////
  // Raise only with a pending burst and a free credit, hold until accepted
  always_ff @(posedge aclk) begin
    if (areset) begin
      awvalid <= 1'b0;
    end else if (!awvalid && !idle_aw && !stall_aw) begin
      awvalid <= 1'b1;
    end else if (awready) begin
      awvalid <= 1'b0;
    end
  end

  // Address steps one full burst per accepted AW
  always_ff @(posedge aclk) begin
    if (plan.plan_start) begin
      addr <= plan.start_addr;
    end else if (plan.awxfer) begin
      addr <= addr + ADDR_WIDTH'(BURST_BYTES);
    end
  end

  assign awaddr = addr;

  // AW burst countdown for the tail length
  always_ff @(posedge aclk) begin
    if (areset) begin
      aw_txn_left <= '0;
    end else if (plan.plan_start) begin
      aw_txn_left <= plan.num_transactions;
    end else if (plan.awxfer) begin
      aw_txn_left <= aw_txn_left - 1'b1;
    end
  end

  assign aw_final_txn = (aw_txn_left == '0);
  assign awlen = aw_final_txn ? plan.final_burst_len : beat_cnt_t'(BURST_LEN - 1);

endmodule : waddr_channel

`default_nettype wire

// File: wdata_channel.sv
// W channel gating, beat and burst counters, wlast, wstrb and first-beat pulse
`default_nettype none

module wdata_channel (
  input  wire logic              aclk,
  input  wire logic              areset,
  input  wire logic              fifo_valid,
  input  wire axi_wm_pkg::data_t fifo_data,
  output logic                   fifo_pop,
  write_plan_if.wdata            plan,
  output logic                   wvalid,
  input  wire logic              wready,
  output axi_wm_pkg::data_t      wdata,
  output axi_wm_pkg::strb_t      wstrb,
  output logic                   wlast
);
  import axi_wm_pkg::*;

  logic      w_running;
  logic      wxfer;
  logic      load_final;
  beat_cnt_t beats_to_go;
  txn_cnt_t  w_txn_left;
  logic      w_final_txn;
  logic      wfirst;
  logic      wfirst_d1;

  // Hold W off until the request size is known
  always_ff @(posedge aclk) begin
    if (areset) begin
      w_running <= 1'b0;
    end else if (plan.plan_start) begin
      w_running <= 1'b1;
    end else if (plan.w_final_transfer) begin
      w_running <= 1'b0;
    end
  end

  assign wvalid   = fifo_valid & w_running;
  assign wxfer    = wvalid & wready;
  assign fifo_pop = wxfer;
  assign wdata    = fifo_data;

  ////////////////////
  // Beat and burst counters
  ////////////////////
  // Tail burst length goes in when the next burst is the last one
  assign load_final = (wxfer & wlast & (w_txn_left == txn_cnt_t'(1)))
                    | (plan.plan_start & plan.single_transaction);

  always_ff @(posedge aclk) begin
    if (areset) begin
      beats_to_go <= beat_cnt_t'(BURST_LEN - 1);
      w_txn_left  <= '0;
    end else begin
      if (load_final) begin
        beats_to_go <= plan.final_burst_len;
      end else if (plan.plan_start) begin
        beats_to_go <= beat_cnt_t'(BURST_LEN - 1);
      end else if (wxfer) begin
        // Wraps back to a full burst after wlast
        beats_to_go <= beats_to_go - 1'b1;
      end
      if (plan.plan_start) begin
        w_txn_left <= plan.num_transactions;
      end else if (wxfer && wlast) begin
        w_txn_left <= w_txn_left - 1'b1;
      end
    end
  end

  assign wlast       = (beats_to_go == '0);
  assign w_final_txn = (w_txn_left == '0);
  assign plan.w_final_transfer = wxfer & wlast & w_final_txn;

  // Partial strobe only on the very last beat of the request
  assign wstrb = (wlast & w_final_txn) ? plan.final_strb : '1;

  ////////////////////
  // First beat of each burst
  ////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      wfirst                <= 1'b1;
      wfirst_d1             <= 1'b0;
      plan.first_beat_pulse <= 1'b0;
    end else begin
      if (wxfer) begin
        wfirst <= wlast;
      end
      wfirst_d1             <= wvalid & wfirst;
      // Rising edge of a presented first beat
      plan.first_beat_pulse <= wvalid & wfirst & ~wfirst_d1;
    end
  end

endmodule : wdata_channel

`default_nettype wire

// File: burst_planner.sv
// Request pop and burst plan computation for the AXI4 write master
`default_nettype none

module burst_planner (
  input  wire logic                    aclk,
  input  wire logic                    areset,
  input  wire logic                    req_valid,
  input  wire axi_wm_pkg::wr_request_t req,
  output logic                         req_pop,
  write_plan_if.planner                plan
);
  import axi_wm_pkg::*;

  logic                       busy;
  logic                       pop_d1;
  wr_request_t                req_r;
  logic [TOTAL_LEN_WIDTH-1:0] total_len_r;
  logic [LOG_DW_BYTES-1:0]    last_lane;
  strb_t                      strb_r;
  addr_t                      addr_r;

  ////////////////////
  // Request pop
  ////////////////////
  // One request in flight; next pop waits for done
  assign req_pop = req_valid & ~busy;

  always_ff @(posedge aclk) begin
    if (areset) begin
      busy       <= 1'b0;
      pop_d1     <= 1'b0;
      plan.plan_start <= 1'b0;
    end else begin
      if (req_pop) begin
        busy <= 1'b1;
      end else if (plan.done) begin
        busy <= 1'b0;
      end
      pop_d1          <= req_pop;
      plan.plan_start <= pop_d1;
    end
  end

  // Head word is captured as it leaves the queue
  always_ff @(posedge aclk) begin
    if (req_pop) begin
      req_r <= req;
    end
  end

  ////////////////////
  // Plan registers
  ////////////////////
  // Last valid byte lane from the raw count, wraps to the top lane on a full beat
  assign last_lane = req_r.size.bytes[LOG_DW_BYTES-1:0] - 1'b1;

  always_ff @(posedge aclk) begin
    if (pop_d1) begin
      // Beats rounded up, in awlen form (count less one)
      total_len_r <= (req_r.size.split.rem != '0) ? req_r.size.split.beats
                                                   : req_r.size.split.beats - 1'b1;
      addr_r      <= req_r.addr;
      for (int i = 0; i < DW_BYTES; i++) begin
        strb_r[i] <= (i <= last_lane);
      end
    end
  end

  // Upper bits count extra bursts, lower bits give the tail burst length
  assign plan.num_transactions   = total_len_r[LOG_BURST_LEN +: TXN_CNTR_WIDTH];
  assign plan.final_burst_len    = total_len_r[0 +: LOG_BURST_LEN];
  assign plan.single_transaction = (plan.num_transactions == '0);
  assign plan.final_strb         = strb_r;
  assign plan.start_addr         = addr_r;

endmodule : burst_planner

`default_nettype wire

// File: write_plan_if.sv
// Burst plan and channel event bundle shared by the write channel blocks
`default_nettype none

interface write_plan_if;
  import axi_wm_pkg::*;

  // Plan fields, held from plan_start until done
  logic      plan_start;
  txn_cnt_t  num_transactions;
  logic      single_transaction;
  beat_cnt_t final_burst_len;
  strb_t     final_strb;
  addr_t     start_addr;

  // Channel events
  logic      first_beat_pulse;
  logic      w_final_transfer;
  logic      done;
  logic      awxfer;
  logic      bxfer;

  modport planner (
    output plan_start, num_transactions, single_transaction,
    output final_burst_len, final_strb, start_addr,
    input  done
  );

  modport wdata (
    input  plan_start, num_transactions, single_transaction,
    input  final_burst_len, final_strb,
    output first_beat_pulse, w_final_transfer
  );

  modport waddr (
    input  plan_start, num_transactions, final_burst_len, start_addr,
    input  first_beat_pulse, bxfer,
    output awxfer
  );

  modport bresp (
    input  plan_start, num_transactions,
    output done, bxfer
  );

endinterface : write_plan_if

`default_nettype wire

// File: sync_fifo.sv
// Synchronous first-word-fall-through FIFO with register array storage
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 16
) (
  input  wire logic             aclk,
  input  wire logic             areset,
  input  wire logic             push,
  input  wire logic [WIDTH-1:0] push_data,
  output logic                  full,
  input  wire logic             pop,
  output logic      [WIDTH-1:0] pop_data,
  output logic                  not_empty
);

  logic [WIDTH-1:0]            mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]    wr_ptr;
  logic [$clog2(DEPTH)-1:0]    rd_ptr;
  logic [$clog2(DEPTH+1)-1:0]  count;
  logic                        push_ok;
  logic                        pop_ok;

  // Qualified handshakes, blocked at the full / empty limits
  assign push_ok = push & ~full;
  assign pop_ok  = pop & not_empty;

  assign full      = (count == DEPTH);
  assign not_empty = (count != 0);

  // Head word shows without a read cycle
  assign pop_data = mem[rd_ptr];

  // Storage, no reset needed
  always_ff @(posedge aclk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_data;
    end
  end

  ////////////////////
  // Pointers and occupancy
  ////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      if (push_ok && !pop_ok) begin
        count <= count + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule : sync_fifo

`default_nettype wire

// File: axi_wm_pkg.sv
// Widths, burst constants and shared types for the AXI4 write master
`default_nettype none

package axi_wm_pkg;

  ////////////////////
  // Bus widths
  ////////////////////
  localparam int ADDR_WIDTH      = 32;
  localparam int DATA_WIDTH      = 32;
  localparam int DW_BYTES        = DATA_WIDTH / 8;
  localparam int LOG_DW_BYTES    = $clog2(DW_BYTES);
  localparam int XFER_SIZE_WIDTH = 20;

  ////////////////////
  // Burst geometry
  ////////////////////
  // Full burst is capped by the 4 KB boundary and by the 256-beat AXI4 limit
  localparam int BURST_LEN = (4096 / DW_BYTES < 256) ? 4096 / DW_BYTES : 256;
  localparam int LOG_BURST_LEN   = $clog2(BURST_LEN);
  localparam int BURST_BYTES     = DW_BYTES * BURST_LEN;
  localparam int TOTAL_LEN_WIDTH = XFER_SIZE_WIDTH - LOG_DW_BYTES;
  localparam int TXN_CNTR_WIDTH  = TOTAL_LEN_WIDTH - LOG_BURST_LEN;

  // Flow control and buffering
  localparam int MAX_OUTSTANDING   = 4;
  localparam int OUTSTANDING_WIDTH = $clog2(MAX_OUTSTANDING + 1);
  localparam int MAX_W_TO_AW_WIDTH = 8;
  localparam int REQ_FIFO_DEPTH    = 4;
  localparam int DATA_FIFO_DEPTH   = 16;

  ////////////////////
  // Types
  ////////////////////
  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [DATA_WIDTH-1:0]     data_t;
  typedef logic [DW_BYTES-1:0]       strb_t;
  typedef logic [TXN_CNTR_WIDTH-1:0] txn_cnt_t;
  typedef logic [LOG_BURST_LEN-1:0]  beat_cnt_t;

  // Byte count split into whole beats and leftover bytes
  typedef struct packed {
    logic [TOTAL_LEN_WIDTH-1:0] beats;
    logic [LOG_DW_BYTES-1:0]    rem;
  } xfer_split_t;

  // Same size word, seen as raw bytes or as beats plus remainder
  typedef union packed {
    logic [XFER_SIZE_WIDTH-1:0] bytes;
    xfer_split_t                split;
  } xfer_size_u;

  // Request queue word
  typedef struct packed {
    addr_t      addr;
    xfer_size_u size;
  } wr_request_t;

endpackage : axi_wm_pkg

`default_nettype wire
